// File: Makefile
# Verilator build and run of the major register testbench

SIM  := obj_dir/Vtb_cft_major_regs
SRCS := $(filter-out +%,$(shell cat all.f)) include/cft_settings.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# Rebuilt only when a source, the header or the file list changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cft_major_regs -f all.f -o Vtb_cft_major_regs

clean:
	rm -rf obj_dir

// File: all.f
+incdir+include
hdl/cft_bus_pkg.sv
hdl/cft_status_pkg.sv
hdl/ustrobe_decode.sv
hdl/major_reg_bank.sv
hdl/reg_readout.sv
hdl/cft_major_regs.sv
testbench/tb_cft_major_regs.sv

// File: hdl/cft_bus_pkg.sv
// Microcode side types; register ids follow the order PC, DR, AC, SP and must not be reordered
package cft_bus_pkg;

`include "cft_settings.svh"

   //////////////////////////////////////////////////////////////////////////////
   // Register identifiers
   //////////////////////////////////////////////////////////////////////////////

   // Index into the register bank, also used for bus and panel selection
   typedef enum logic [1:0] {
      maj_pc = 2'd0,
      maj_dr = 2'd1,
      maj_ac = 2'd2,
      maj_sp = 2'd3
   } major_id_t;

   //////////////////////////////////////////////////////////////////////////////
   // Microcode control word
   //////////////////////////////////////////////////////////////////////////////

   // Raw strobes as they leave the sequencer, all active high
   typedef struct packed {
      logic      write_en;   // Load write_id from the bus
      major_id_t write_id;
      logic      read_en;    // Drive the bus from read_id
      major_id_t read_id;
      logic      inc_en;     // Count step_id up
      logic      dec_en;     // Count step_id down
      major_id_t step_id;
   } ustrobe_t;

   // Decoded word carried into the bank stage
   // Bus word travels with its strobes so a load sees its own cycle's data
   typedef struct packed {
      ustrobe_t                   op;
      logic [`CFT_WORD_WIDTH-1:0] bus_word;
   } uctl_t;

endpackage

// File: hdl/cft_major_regs.sv
// Top of the major register block; outputs trail their microcode word by three clk edges, no stall
`timescale 1ns/1ps

`include "cft_settings.svh"

module cft_major_regs
   import cft_bus_pkg::*;
   import cft_status_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  ustrobe_t                    ustrobe,
   input  logic [`CFT_WORD_WIDTH-1:0]  ibus_in,
   input  panel_sel_t                  panel_sel,
   output logic [`CFT_WORD_WIDTH-1:0]  ibus_out,
   output logic                        ibus_drive,
   output logic [`CFT_WORD_WIDTH-1:0]  pc_out,
   output logic [`CFT_WORD_WIDTH-1:0]  ac_out,
   output logic                        fz,
   output logic                        fn,
   output logic                        naccpl,
   output logic [`CFT_PANEL_WIDTH-1:0] fpd
);

   uctl_t      ctl;
   bank_view_t view;
   ac_flags_t  flags;

   // Decode, bank, readout
   ustrobe_decode u_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .ustrobe (ustrobe),
      .ibus_in (ibus_in),
      .ctl     (ctl)
   );

   major_reg_bank u_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .ctl   (ctl),
      .view  (view)
   );

   reg_readout u_readout (
      .clk        (clk),
      .rst_n      (rst_n),
      .view       (view),
      .panel_sel  (panel_sel),
      .ibus_out   (ibus_out),
      .ibus_drive (ibus_drive),
      .pc_out     (pc_out),
      .ac_out     (ac_out),
      .flags      (flags),
      .fpd        (fpd)
   );

   assign fz     = flags.fz;
   assign fn     = flags.fn;
   // L toggle leaves the block active low, as the L register expects
   assign naccpl = ~flags.accpl;

endmodule

// File: hdl/cft_status_pkg.sv
// Status side types; flags are active high inside the block, only the top inverts the L toggle
package cft_status_pkg;

`include "cft_settings.svh"

   // AC condition outputs
   typedef struct packed {
      logic fz;     // AC is zero
      logic fn;     // AC bit 15 set
      logic accpl;  // One cycle pulse, toggle L on AC wrap
   } ac_flags_t;

   // Front panel byte select
   typedef struct packed {
      cft_bus_pkg::major_id_t panel_id;
      logic                   panel_hi;  // High byte when set
   } panel_sel_t;

   //////////////////////////////////////////////////////////////////////////////
   // Bank stage results seen by the readout stage
   //////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [`CFT_NUM_MAJOR-1:0][`CFT_WORD_WIDTH-1:0] regs;
      logic                                           ac_wrap;
      // Read request delayed to line up with the updated registers
      logic                                           read_en;
      cft_bus_pkg::major_id_t                         read_id;
   } bank_view_t;

endpackage

// File: hdl/major_reg_bank.sv
// Second stage; PC cannot count down, a load beats a step on the same register, other steps proceed
`timescale 1ns/1ps

`include "cft_settings.svh"

module major_reg_bank
   import cft_bus_pkg::*;
   import cft_status_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  uctl_t      ctl,
   output bank_view_t view
);

   // Capability table
   //   reg  inc  dec
   //   PC    Y    -
   //   DR    Y    Y
   //   AC    Y    Y
   //   SP    Y    Y
   // Every register counts up, so only the down direction needs a mask
   // Bit order follows major_id_t, PC in bit 0
   localparam logic [`CFT_NUM_MAJOR-1:0] can_dec = 4'b1110;

   logic [`CFT_NUM_MAJOR-1:0][`CFT_WORD_WIDTH-1:0] regs;
   logic [`CFT_NUM_MAJOR-1:0][`CFT_WORD_WIDTH-1:0] regs_next;

   // One-hot register selects for this word
   logic [`CFT_NUM_MAJOR-1:0] load_sel;
   logic [`CFT_NUM_MAJOR-1:0] inc_sel;
   logic [`CFT_NUM_MAJOR-1:0] dec_sel;

   logic      ac_wrap_next;
   logic      ac_wrap;
   logic      read_en_q;
   major_id_t read_id_q;

   //////////////////////////////////////////////////////////////////////////////
   // Strobe fan-out
   //////////////////////////////////////////////////////////////////////////////

   assign load_sel = ctl.op.write_en ?
                     (`CFT_NUM_MAJOR'(1) << ctl.op.write_id) : '0;
   assign inc_sel  = ctl.op.inc_en ?
                     (`CFT_NUM_MAJOR'(1) << ctl.op.step_id) : '0;
   // Unsupported decrements fall out here
   assign dec_sel  = ctl.op.dec_en ?
                     ((`CFT_NUM_MAJOR'(1) << ctl.op.step_id) & can_dec) : '0;

   //////////////////////////////////////////////////////////////////////////////
   // Next register values
   //////////////////////////////////////////////////////////////////////////////

   always_comb begin
      regs_next = regs;
      for (int i = 0; i < `CFT_NUM_MAJOR; i++) begin
         // Parallel load has priority, like the counter load pin
         if (load_sel[i]) begin
            regs_next[i] = ctl.bus_word;
         end else if (inc_sel[i]) begin
            regs_next[i] = regs[i] + `CFT_WORD_WIDTH'(1);
         end else if (dec_sel[i]) begin
            regs_next[i] = regs[i] - `CFT_WORD_WIDTH'(1);
         end
      end
   end

   // AC carry or borrow out of the top nibble
   // Only counts when the step really lands, so a load masks it
   assign ac_wrap_next = !load_sel[maj_ac] &&
                         ((inc_sel[maj_ac] && (regs[maj_ac] == '1)) ||
                          (dec_sel[maj_ac] && (regs[maj_ac] == '0)));

   //////////////////////////////////////////////////////////////////////////////
   // Stage registers
   //////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs      <= '0;
         ac_wrap   <= 1'b0;
         read_en_q <= 1'b0;
         read_id_q <= maj_pc;
      end else begin
         regs      <= regs_next;
         ac_wrap   <= ac_wrap_next;
         // Read request rides one stage so it sees this word's update
         read_en_q <= ctl.op.read_en;
         read_id_q <= ctl.op.read_id;
      end
   end

   assign view = '{
      regs:    regs,
      ac_wrap: ac_wrap,
      read_en: read_en_q,
      read_id: read_id_q
   };

   // PC has no down counter
   a_no_pc_dec : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ctl.op.dec_en && (ctl.op.step_id == maj_pc))
   );

endmodule

// File: hdl/reg_readout.sv
// Third stage; the bus is modelled as a registered word plus drive strobe, no tri-state or contention check
`timescale 1ns/1ps

`include "cft_settings.svh"

module reg_readout
   import cft_bus_pkg::*;
   import cft_status_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  bank_view_t                  view,
   input  panel_sel_t                  panel_sel,
   output logic [`CFT_WORD_WIDTH-1:0]  ibus_out,
   output logic                        ibus_drive,
   output logic [`CFT_WORD_WIDTH-1:0]  pc_out,
   output logic [`CFT_WORD_WIDTH-1:0]  ac_out,
   output ac_flags_t                   flags,
   output logic [`CFT_PANEL_WIDTH-1:0] fpd
);

   logic [`CFT_WORD_WIDTH-1:0] ac_word;
   logic [`CFT_WORD_WIDTH-1:0] panel_word;

   assign ac_word    = view.regs[maj_ac];
   // Panel looks at the same register values as this edge's readout
   assign panel_word = view.regs[panel_sel.panel_id];

   //////////////////////////////////////////////////////////////////////////////
   // Control and flags
   //////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ibus_drive  <= 1'b0;
         // AC clears to zero, so the zero flag starts set
         flags.fz    <= 1'b1;
         flags.fn    <= 1'b0;
         flags.accpl <= 1'b0;
      end else begin
         // Stands in for the 541 output enables
         ibus_drive  <= view.read_en;
         flags.fz    <= (ac_word == '0);
         flags.fn    <= ac_word[`CFT_WORD_WIDTH-1];
         // Wrap bit is per word, so this stays a single-cycle pulse
         flags.accpl <= view.ac_wrap;
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Data outputs
   //////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Bus read mux, only meaningful while ibus_drive is high
      ibus_out <= view.regs[view.read_id];
      pc_out   <= view.regs[maj_pc];
      ac_out   <= ac_word;
      if (panel_sel.panel_hi) begin
         fpd <= panel_word[`CFT_WORD_WIDTH-1 -: `CFT_PANEL_WIDTH];
      end else begin
         fpd <= panel_word[`CFT_PANEL_WIDTH-1:0];
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // L toggle checks
   //////////////////////////////////////////////////////////////////////////////

   // A real wrap leaves AC at one end of its range
   a_accpl_at_edge : assert property (
      @(posedge clk) disable iff (!rst_n)
      flags.accpl |-> ((ac_out == '0) || (ac_out == '1))
   );

   // Back to back pulses need two wrapping words in a row
   // That can only be an up then down, or down then up, so AC flips end to end
   a_accpl_pair : assert property (
      @(posedge clk) disable iff (!rst_n)
      (flags.accpl && $past(flags.accpl)) |-> (ac_out == ~$past(ac_out))
   );

endmodule

// File: hdl/ustrobe_decode.sv
// First stage; assumes the sequencer never asks for both step directions, an opposing pair becomes a no-op
`timescale 1ns/1ps

`include "cft_settings.svh"

module ustrobe_decode
   import cft_bus_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  ustrobe_t                   ustrobe,
   input  logic [`CFT_WORD_WIDTH-1:0] ibus_in,
   output uctl_t                      ctl
);

   //////////////////////////////////////////////////////////////////////////////
   // Strobe validation
   //////////////////////////////////////////////////////////////////////////////

   ustrobe_t                   op_clean;
   ustrobe_t                   op_q;
   logic [`CFT_WORD_WIDTH-1:0] word_q;

   always_comb begin
      op_clean = ustrobe;
      // Up and down together would fight in a counter
      // Drop both so the register just holds
      if (ustrobe.inc_en && ustrobe.dec_en) begin
         op_clean.inc_en = 1'b0;
         op_clean.dec_en = 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Stage register
   //////////////////////////////////////////////////////////////////////////////

   // Strobes come back from reset as a no-op word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q <= '0;
      end else begin
         op_q <= op_clean;
      end
   end

   // Bus word captured alongside, meaningful only with write_en
   always_ff @(posedge clk) begin
      word_q <= ibus_in;
   end

   assign ctl = '{op: op_q, bus_word: word_q};

   //////////////////////////////////////////////////////////////////////////////
   // Sequencer contract
   //////////////////////////////////////////////////////////////////////////////

   // Microcode never steps a register both ways at once
   a_no_inc_dec : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ustrobe.inc_en && ustrobe.dec_en)
   );

   // Tri-state bus origin: one register cannot drive and load the bus together
   a_no_self_xfer : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ustrobe.read_en && ustrobe.write_en && (ustrobe.read_id == ustrobe.write_id))
   );

endmodule

// File: include/cft_settings.svh
// Global sizes for the major register block; widths other than a 16-bit word and byte panel are untested
`ifndef CFT_SETTINGS_SVH
`define CFT_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////////////////////////////////

// Width of one major register and of the internal bus
`define CFT_WORD_WIDTH 16

// PC, DR, AC and SP
`define CFT_NUM_MAJOR 4

// Front panel shows one byte of a register at a time
`define CFT_PANEL_WIDTH 8

// Edges from a microcode word to its visible results
`define CFT_PIPE_DEPTH 3

`endif

// File: testbench/major_regs_golden.txt
// wen wid ren rid inc dec sid ibus_in pid phi | ibus_out drv pc_out ac_out fz fn naccpl fpd
// Hex; expected outputs belong to the word on the same line, ids 0 PC 1 DR 2 AC 3 SP
1 0 0 0 0 0 0 1234 0 1   0000 0 1234 0000 1 0 1 12
1 1 1 0 0 0 0 A5C3 1 0   1234 1 1234 0000 1 0 1 C3
1 2 1 1 0 0 0 FFFF 2 1   A5C3 1 1234 FFFF 0 1 1 FF
1 3 1 2 0 0 0 0F00 3 1   FFFF 1 1234 FFFF 0 1 1 0F
0 0 1 3 1 0 2 0000 3 0   0F00 1 1234 0000 1 0 0 00
0 0 1 2 0 0 0 0000 2 0   0000 1 1234 0000 1 0 1 00
0 0 0 0 0 1 2 0000 2 0   0000 0 1234 FFFF 0 1 0 FF
0 0 1 2 1 0 0 0000 0 0   FFFF 1 1235 FFFF 0 1 1 35
0 0 1 0 0 1 1 0000 1 1   1235 1 1235 FFFF 0 1 1 A5
0 0 1 1 1 0 3 0000 3 0   A5C2 1 1235 FFFF 0 1 1 01
0 0 1 3 0 1 3 0000 3 1   0F00 1 1235 FFFF 0 1 1 0F
1 2 1 3 1 0 2 8001 2 0   0F00 1 1235 8001 0 1 1 01
1 1 1 2 0 0 0 00FF 1 0   8001 1 1235 8001 0 1 1 FF
0 0 1 1 1 0 1 0000 1 1   0100 1 1235 8001 0 1 1 01
0 0 1 1 0 1 1 0000 1 0   00FF 1 1235 8001 0 1 1 FF
1 0 1 1 1 0 0 7FFE 0 1   00FF 1 7FFE 8001 0 1 1 7F
0 0 1 0 0 1 2 0000 2 0   7FFE 1 7FFE 8000 0 1 1 00
1 2 1 3 0 0 0 0000 2 1   0F00 1 7FFE 0000 1 0 1 00

// File: testbench/tb_cft_major_regs.sv
// Testbench for the major register block; needs the golden file path relative to the project root
`timescale 1ns/1ps

`include "cft_settings.svh"

module tb_cft_major_regs
   import cft_bus_pkg::*;
   import cft_status_pkg::*;
;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   // Ten stimulus and eight expected hex fields per golden line
   localparam int COLS         = 18;
   localparam int MAX_ROWS     = 64;
   // Bit 16 cannot come from a 4-digit token
   // Set in every unused entry, the low bits carry the address
   localparam logic [16:0] EMPTY = 17'h1_0000;

   logic                        clk;
   logic                        rst_n;
   ustrobe_t                    ustrobe;
   logic [`CFT_WORD_WIDTH-1:0]  ibus_in;
   panel_sel_t                  panel_sel;
   logic [`CFT_WORD_WIDTH-1:0]  ibus_out;
   logic                        ibus_drive;
   logic [`CFT_WORD_WIDTH-1:0]  pc_out;
   logic [`CFT_WORD_WIDTH-1:0]  ac_out;
   logic                        fz;
   logic                        fn;
   logic                        naccpl;
   logic [`CFT_PANEL_WIDTH-1:0] fpd;

   logic [16:0] gold [0:MAX_ROWS*COLS-1];
   int          num_rows;
   bit          rows_loaded;

   cft_major_regs dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .ustrobe    (ustrobe),
      .ibus_in    (ibus_in),
      .panel_sel  (panel_sel),
      .ibus_out   (ibus_out),
      .ibus_drive (ibus_drive),
      .pc_out     (pc_out),
      .ac_out     (ac_out),
      .fz         (fz),
      .fn         (fn),
      .naccpl     (naccpl),
      .fpd        (fpd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Golden file decoding
   ////////////////////////////////////////////////////////////////////////////

   // Largest legal value of each column
   function automatic logic [16:0] field_max(input int col);
      case (col)
         1, 3, 6, 8:      field_max = 17'h3;
         7, 10, 12, 13:   field_max = 17'hFFFF;
         17:              field_max = 17'hFF;
         default:         field_max = 17'h1;
      endcase
   endfunction

   function automatic ustrobe_t strobe_at(input int row);
      ustrobe_t s;
      int       b;
      b = row * COLS;
      s.write_en = gold[b][0];
      s.write_id = major_id_t'(gold[b+1][1:0]);
      s.read_en  = gold[b+2][0];
      s.read_id  = major_id_t'(gold[b+3][1:0]);
      s.inc_en   = gold[b+4][0];
      s.dec_en   = gold[b+5][0];
      s.step_id  = major_id_t'(gold[b+6][1:0]);
      return s;
   endfunction

   function automatic panel_sel_t panel_at(input int row);
      panel_sel_t p;
      p.panel_id = major_id_t'(gold[row*COLS+8][1:0]);
      p.panel_hi = gold[row*COLS+9][0];
      return p;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input logic [`CFT_WORD_WIDTH-1:0] actual,
                              input logic [`CFT_WORD_WIDTH-1:0] expected,
                              input string label);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, label, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "stopped at the first wrong output");
      end
   endtask

   // Outputs belonging to one golden line
   task automatic check_row(input int row);
      int    b;
      string tag;
      b   = row * COLS;
      tag = $sformatf("row %0d", row);
      check_value(16'(ibus_drive), 16'(gold[b+11]), {tag, " ibus_drive"});
      // Bus word only means something while driven
      if (gold[b+11][0]) begin
         check_value(ibus_out, 16'(gold[b+10]), {tag, " ibus_out"});
      end
      check_value(pc_out, 16'(gold[b+12]), {tag, " pc_out"});
      check_value(ac_out, 16'(gold[b+13]), {tag, " ac_out"});
      check_value(16'(fz), 16'(gold[b+14]), {tag, " fz"});
      check_value(16'(fn), 16'(gold[b+15]), {tag, " fn"});
      check_value(16'(naccpl), 16'(gold[b+16]), {tag, " naccpl"});
      check_value(16'(fpd), 16'(gold[b+17]), {tag, " fpd"});
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int fd;
      int count;
      rst_n       = 1'b0;
      ustrobe     = '0;
      ibus_in     = '0;
      panel_sel   = '0;
      rows_loaded = 1'b0;
      num_rows    = 0;
      count       = 0;

      fd = $fopen("testbench/major_regs_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open testbench/major_regs_golden.txt");
         $display("TEST RESULT: FAIL");
         $fatal(1, "golden file missing");
      end
      $fclose(fd);
      for (int i = 0; i < MAX_ROWS * COLS; i++) begin
         gold[i] = EMPTY | 17'(i);
      end
      $readmemh("testbench/major_regs_golden.txt", gold);
      while (count < MAX_ROWS * COLS && !gold[count][16]) begin
         if (gold[count] > field_max(count % COLS)) begin
            $display("golden file line %0d has an out of range field", count / COLS);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bad golden line");
         end
         count++;
      end
      if (count == 0 || count % COLS != 0) begin
         $display("golden file is empty or a line has the wrong number of fields");
         $display("TEST RESULT: FAIL");
         $fatal(1, "bad golden file");
      end
      num_rows    = count / COLS;
      rows_loaded = 1'b1;

      // The last reset edge comes from the first loop pass
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_value(16'(ibus_drive), 16'h0, "reset ibus_drive");
      check_value(16'(naccpl), 16'h1, "reset naccpl");
      check_value(pc_out, 16'h0, "reset pc_out");
      check_value(ac_out, 16'h0, "reset ac_out");
      check_value(16'(fz), 16'h1, "reset fz");
      check_value(16'(fn), 16'h0, "reset fn");

      // Word k enters now and its outputs are read three edges later
      // Panel select for a row goes in one edge ahead of that row's readout edge
      for (int k = 0; k < num_rows + `CFT_PIPE_DEPTH; k++) begin
         @(posedge clk);
         rst_n <= 1'b1;
         if (k < num_rows) begin
            ustrobe <= strobe_at(k);
            ibus_in <= 16'(gold[k*COLS+7]);
         end else begin
            ustrobe <= '0;
            ibus_in <= '0;
         end
         if (k >= `CFT_PIPE_DEPTH - 1 && k - (`CFT_PIPE_DEPTH - 1) < num_rows) begin
            panel_sel <= panel_at(k - (`CFT_PIPE_DEPTH - 1));
         end else begin
            panel_sel <= '0;
         end
         @(negedge clk);
         if (k >= `CFT_PIPE_DEPTH) begin
            check_row(k - `CFT_PIPE_DEPTH);
         end
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

   // Watchdog sized from the golden file length
   initial begin
      wait (rows_loaded);
      #((num_rows + RESET_CYCLES + `CFT_PIPE_DEPTH + 10) * CLK_PERIOD);
      $display("timeout, the run did not reach the end of the golden file");
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule
